// ==== compile.f ====
verilog/uart_reg_pkg.sv
verilog/uart_serial_pkg.sv
verilog/uart_wb_ctrl.sv
verilog/uart_bank.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart.sv
dv/uart_tb.sv

// ==== dv/uart_stim.txt ====
# Columns: op, then hex fields. W addr data, R addr expected, S byte driven on rxd,
# T byte expected on txd, I irq level, D idle cycles
# Reset values
R 6 00000055
R 2 00000000
R 3 00000000
R 4 00000000
R 1 80000000
I 0
# Register read-back within field widths
W 2 ffffffff
R 2 000f0003
W 2 00000000
W 3 ffffffff
R 3 000f0001
W 3 00000000
W 4 ffffffff
R 4 00000003
W 4 00000000
W 6 ffff1234
R 6 00001234
W 6 00000003
# Transmit with one stop bit, then two
W 0 000000a5
W 0 0000003c
W 2 00000001
T a5
T 3c
W 2 00000000
W 0 00000081
W 0 0000007e
W 2 00000003
T 81
T 7e
W 2 00000000
# Receive
W 3 00000001
S 55
S c3
S 0f
R 1 00000055
R 1 000000c3
R 1 0000000f
R 1 80000000
# Full transmit FIFO, last two writes dropped
W 0 00000001
W 0 00000002
W 0 00000003
W 0 00000004
W 0 00000005
W 0 00000006
W 0 00000007
W 0 00000008
W 0 00000009
W 0 0000000a
R 0 80000000
W 2 00000001
T 01
T 02
T 03
T 04
T 05
T 06
T 07
T 08
W 0 0000005a
T 5a
R 0 00000000
W 2 00000000
# Watermarks, RX count field 1 and RXWM enabled
W 3 00010001
W 4 00000002
W 2 00020000
R 5 00000001
W 0 00000011
W 0 00000022
S 9a
I 0
S 6b
I 1
R 5 00000002
R 1 0000009a
D 2
I 0
R 1 0000006b
R 1 80000000
W 2 00020001
T 11
T 22
R 5 00000001
I 0

// ==== dv/uart_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tb
  import uart_reg_pkg::*;
  import uart_serial_pkg::*;
;

  localparam int    FIFO_DEPTH    = 8;
  localparam int    CLOCK_FREQ_HZ = 10000000;
  localparam int    CNT_W         = $clog2(FIFO_DEPTH) + 1;
  localparam string STIM_FILE     = "dv/uart_stim.txt";

  logic      clk_i;
  logic      rst;
  logic      cyc_i;
  logic      stb_i;
  logic      we_i;
  reg_addr_t adr_i;
  wb_data_t  dat_i;
  wb_data_t  dat_o;
  logic      ack_o;
  logic      rxd;
  logic      txd;
  logic      irq;

  // Reference state built from the register writes
  div_t             div_model;
  logic             nstop_model;
  logic [CNT_W-1:0] tx_wm_model;
  int               tx_level;
  int               op_count;

  uart #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .CLOCK_FREQ_HZ (CLOCK_FREQ_HZ)
  ) DUT (
    .clk_i (clk_i),
    .rst   (rst),
    .cyc_i (cyc_i),
    .stb_i (stb_i),
    .we_i  (we_i),
    .adr_i (adr_i),
    .dat_i (dat_i),
    .dat_o (dat_o),
    .ack_o (ack_o),
    .rxd   (rxd),
    .txd   (txd),
    .irq   (irq)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] actual,
                       input logic [31:0] expected);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch %s: got 0x%08h, expected 0x%08h", name, actual, expected));
    end
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk_i);
      #1;
    end
  endtask

  function automatic logic is_blank(input logic [7:0] c);
    return (c == " ") || (c == "\n") || (c == "\r") || (c == "\t");
  endfunction

  task automatic bus_access(input logic write, input reg_addr_t addr, input wb_data_t wdata,
                            output wb_data_t rdata);
    int gap;
    int waited;
    gap = 1 + int'($urandom % 3);
    // Idle bus, ack must stay low
    repeat (gap) begin
      @(posedge clk_i);
      #1;
      check("ack_o idle", 32'(ack_o), 32'h0);
    end
    cyc_i = 1'b1;
    stb_i = 1'b1;
    we_i  = write;
    adr_i = addr;
    dat_i = wdata;
    waited = 0;
    while (ack_o !== 1'b1 && waited < 16) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (ack_o !== 1'b1) begin
      abort_run("Timed out waiting for ack_o on a bus access");
    end else begin
      // Request edge, then bank edge, then ack is visible
      check("ack_o latency", 32'(waited), 32'd2);
      rdata = dat_o;
      cyc_i = 1'b0;
      stb_i = 1'b0;
      we_i  = 1'b0;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input wb_data_t data);
    wb_data_t unused;
    bus_access(1'b1, addr, data, unused);
    case (addr)
      ADDR_TXDATA: begin
        if (tx_level < FIFO_DEPTH) begin
          tx_level++;
        end
      end
      ADDR_TXCTRL: begin
        nstop_model = data[NSTOP_BIT];
        tx_wm_model = data[CNT_LSB +: CNT_W];
      end
      ADDR_DIV: div_model = data[15:0];
      default: ;
    endcase
  endtask

  task automatic read_reg(input reg_addr_t addr, input wb_data_t expected);
    wb_data_t got;
    bus_access(1'b0, addr, 32'h0, got);
    check($sformatf("dat_o addr %0d", addr), got, expected);
    // FIFO level is accepted writes minus frames seen on txd
    if (addr == ADDR_IP) begin
      check("ip txwm", 32'(got[TXWM_BIT]), 32'(tx_level < int'(tx_wm_model)));
    end
  endtask

  task automatic send_frame(input byte_t data);
    int i;
    int bit_len;
    bit_len = int'(div_model) + 1;
    rxd = 1'b0;
    wait_cycles(bit_len);
    for (i = 0; i < 8; i++) begin
      rxd = data[i];
      wait_cycles(bit_len);
    end
    // Stop bit plus one idle bit so the byte is in the FIFO on return
    rxd = 1'b1;
    wait_cycles(2 * bit_len);
  endtask

  task automatic expect_frame(input byte_t expected);
    int    i;
    int    bit_len;
    int    waited;
    byte_t got;
    bit_len = int'(div_model) + 1;
    waited = 0;
    while (txd !== 1'b0 && waited < 12 * bit_len + 16) begin
      @(posedge clk_i);
      #1;
      waited++;
    end
    if (txd !== 1'b0) begin
      abort_run("Timed out waiting for a start bit on txd");
    end else begin
      wait_cycles(bit_len / 2);
      check("txd start bit", 32'(txd), 32'h0);
      for (i = 0; i < 8; i++) begin
        wait_cycles(bit_len);
        got[i] = txd;
      end
      for (i = 0; i <= int'(nstop_model); i++) begin
        wait_cycles(bit_len);
        check("txd stop bit", 32'(txd), 32'h1);
      end
      check("txd byte", 32'(got), 32'(expected));
      if (tx_level > 0) begin
        tx_level--;
      end
    end
  endtask

  task automatic run_op(input int fd, input logic [7:0] op);
    int          code;
    int          nfields;
    logic [31:0] a;
    logic [31:0] b;
    if (op == "W" || op == "R") begin
      nfields = 2;
      code = $fscanf(fd, "%h %h", a, b);
    end else begin
      nfields = 1;
      code = $fscanf(fd, "%h", a);
    end
    if (code != nfields) begin
      abort_run("Malformed line in the stim file");
    end else begin
      case (op)
        "W": write_reg(a[2:0], b);
        "R": read_reg(a[2:0], b);
        "S": send_frame(a[7:0]);
        "T": expect_frame(a[7:0]);
        "I": check("irq", 32'(irq), a);
        "D": wait_cycles(int'(a));
        default: abort_run($sformatf("Unknown operation %c in the stim file", op));
      endcase
    end
  endtask

  initial begin
    int                fd;
    int                code;
    logic              done;
    logic [7:0]        op;
    logic [8*128-1:0]  line;
    rst   = 1'b1;
    cyc_i = 1'b0;
    stb_i = 1'b0;
    we_i  = 1'b0;
    adr_i = '0;
    dat_i = '0;
    rxd   = 1'b1;
    div_model   = div_t'(CLOCK_FREQ_HZ / 115200 - 1);
    nstop_model = 1'b0;
    tx_wm_model = '0;
    tx_level    = 0;
    op_count    = 0;
    void'($urandom(32'h2306));
    repeat (5) @(posedge clk_i);
    #1;
    rst = 1'b0;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      abort_run("Could not open the stim file");
    end else begin
      done = 1'b0;
      while (!done) begin
        code = $fscanf(fd, "%c", op);
        if (code != 1) begin
          done = 1'b1;
        end else if (op == "#") begin
          code = $fgets(line, fd);
        end else if (!is_blank(op)) begin
          run_op(fd, op);
          op_count++;
        end
      end
      $fclose(fd);
      if (op_count == 0) begin
        abort_run("The stim file held no operations");
      end else begin
        $display("Simulation finished: PASS");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary -Wno-fatal --top-module uart_tb -f compile.f -Mdir obj_dir -o uart_sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out=$(./obj_dir/uart_sim 2>&1)
sim_status=$?
echo "$sim_out"

if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -qxF "Simulation finished: PASS"; then
  exit 0
fi

echo "Pass message not found in the simulation output"
exit 1

// ==== verilog/uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart
  import uart_reg_pkg::*;
  import uart_serial_pkg::*;
#(
  parameter int FIFO_DEPTH    = 8,
  parameter int CLOCK_FREQ_HZ = 10000000
) (
  input  logic      clk_i,
  input  logic      rst,
  input  logic      cyc_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  reg_addr_t adr_i,
  input  wb_data_t  dat_i,
  output wb_data_t  dat_o,
  output logic      ack_o,
  input  logic      rxd,
  output logic      txd,
  output logic      irq
);

  reg_addr_t                   addr;
  wb_data_t                    wr_data;
  logic                        bank_wr_en;
  logic                        bank_rd_en;
  logic                        tx_push;
  byte_t                       tx_push_data;
  byte_t                       tx_head;
  logic                        tx_pop;
  logic                        tx_full;
  logic                        tx_empty;
  logic [$clog2(FIFO_DEPTH):0] tx_count;
  logic                        rx_push;
  byte_t                       rx_push_data;
  byte_t                       rx_head;
  logic                        rx_pop;
  logic                        rx_empty;
  logic [$clog2(FIFO_DEPTH):0] rx_count;
  logic                        txen;
  logic                        rxen;
  logic                        nstop;
  div_t                        div;

  uart_wb_ctrl wb_ctrl (
    .clk_i      (clk_i),
    .rst        (rst),
    .cyc_i      (cyc_i),
    .stb_i      (stb_i),
    .we_i       (we_i),
    .adr_i      (adr_i),
    .dat_i      (dat_i),
    .addr       (addr),
    .wr_data    (wr_data),
    .bank_wr_en (bank_wr_en),
    .bank_rd_en (bank_rd_en),
    .ack_o      (ack_o)
  );

  uart_bank #(
    .FIFO_DEPTH    (FIFO_DEPTH),
    .CLOCK_FREQ_HZ (CLOCK_FREQ_HZ)
  ) bank (
    .clk_i        (clk_i),
    .rst          (rst),
    .addr         (addr),
    .wr_data      (wr_data),
    .bank_wr_en   (bank_wr_en),
    .bank_rd_en   (bank_rd_en),
    .dat_o        (dat_o),
    .tx_push      (tx_push),
    .tx_push_data (tx_push_data),
    .tx_full      (tx_full),
    .tx_count     (tx_count),
    .rx_pop       (rx_pop),
    .rx_head      (rx_head),
    .rx_empty     (rx_empty),
    .rx_count     (rx_count),
    .txen         (txen),
    .rxen         (rxen),
    .nstop        (nstop),
    .div          (div),
    .irq          (irq)
  );

  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) tx_fifo (
    .clk_i     (clk_i),
    .rst       (rst),
    .push      (tx_push),
    .push_data (tx_push_data),
    .pop       (tx_pop),
    .head      (tx_head),
    .full      (tx_full),
    .empty     (tx_empty),
    .count     (tx_count)
  );

  // Receive full flag is not reported, an overflowing byte is dropped
  uart_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) rx_fifo (
    .clk_i     (clk_i),
    .rst       (rst),
    .push      (rx_push),
    .push_data (rx_push_data),
    .pop       (rx_pop),
    .head      (rx_head),
    .full      (),
    .empty     (rx_empty),
    .count     (rx_count)
  );

  uart_tx serial_tx (
    .clk_i    (clk_i),
    .rst      (rst),
    .txen     (txen),
    .nstop    (nstop),
    .div      (div),
    .tx_head  (tx_head),
    .tx_empty (tx_empty),
    .tx_pop   (tx_pop),
    .txd      (txd)
  );

  uart_rx serial_rx (
    .clk_i        (clk_i),
    .rst          (rst),
    .rxen         (rxen),
    .div          (div),
    .rxd          (rxd),
    .rx_push      (rx_push),
    .rx_push_data (rx_push_data)
  );

endmodule

`default_nettype wire

// ==== verilog/uart_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_bank
  import uart_reg_pkg::*;
  import uart_serial_pkg::*;
#(
  parameter int FIFO_DEPTH    = 8,
  parameter int CLOCK_FREQ_HZ = 10000000
) (
  input  logic                        clk_i,
  input  logic                        rst,
  input  reg_addr_t                   addr,
  input  wb_data_t                    wr_data,
  input  logic                        bank_wr_en,
  input  logic                        bank_rd_en,
  output wb_data_t                    dat_o,
  output logic                        tx_push,
  output byte_t                       tx_push_data,
  input  logic                        tx_full,
  input  logic [$clog2(FIFO_DEPTH):0] tx_count,
  output logic                        rx_pop,
  input  byte_t                       rx_head,
  input  logic                        rx_empty,
  input  logic [$clog2(FIFO_DEPTH):0] rx_count,
  output logic                        txen,
  output logic                        rxen,
  output logic                        nstop,
  output div_t                        div,
  output logic                        irq
);

  localparam int CNT_W     = $clog2(FIFO_DEPTH) + 1;
  localparam int RESET_DIV = CLOCK_FREQ_HZ / 115200 - 1;

  logic [CNT_W-1:0] tx_wm;
  logic [CNT_W-1:0] rx_wm;
  logic             ie_txwm;
  logic             ie_rxwm;
  logic             txwm;
  logic             rxwm;
  wb_data_t         rd_word;

  assign tx_push      = bank_wr_en && (addr == ADDR_TXDATA) && !tx_full;
  assign tx_push_data = wr_data[7:0];
  assign rx_pop       = bank_rd_en && (addr == ADDR_RXDATA) && !rx_empty;

  // Watermark pending conditions
  assign txwm = (tx_count < tx_wm);
  assign rxwm = (rx_count > rx_wm);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      txen    <= 1'b0;
      nstop   <= 1'b0;
      tx_wm   <= '0;
      rxen    <= 1'b0;
      rx_wm   <= '0;
      ie_txwm <= 1'b0;
      ie_rxwm <= 1'b0;
      div     <= div_t'(RESET_DIV);
    end else if (bank_wr_en) begin
      case (addr)
        ADDR_TXCTRL: begin
          txen  <= wr_data[EN_BIT];
          nstop <= wr_data[NSTOP_BIT];
          tx_wm <= wr_data[CNT_LSB +: CNT_W];
        end
        ADDR_RXCTRL: begin
          rxen  <= wr_data[EN_BIT];
          rx_wm <= wr_data[CNT_LSB +: CNT_W];
        end
        ADDR_IE: begin
          ie_txwm <= wr_data[TXWM_BIT];
          ie_rxwm <= wr_data[RXWM_BIT];
        end
        ADDR_DIV: begin
          div <= wr_data[15:0];
        end
        default: ;
      endcase
    end
  end

  always_comb begin
    rd_word = '0;
    case (addr)
      ADDR_TXDATA: rd_word[FULL_BIT] = tx_full;
      ADDR_RXDATA: begin
        if (rx_empty) begin
          rd_word[EMPTY_BIT] = 1'b1;
        end else begin
          rd_word[7:0] = rx_head;
        end
      end
      ADDR_TXCTRL: begin
        rd_word[EN_BIT]              = txen;
        rd_word[NSTOP_BIT]           = nstop;
        rd_word[CNT_LSB +: CNT_W]    = tx_wm;
      end
      ADDR_RXCTRL: begin
        rd_word[EN_BIT]              = rxen;
        rd_word[CNT_LSB +: CNT_W]    = rx_wm;
      end
      ADDR_IE: begin
        rd_word[TXWM_BIT] = ie_txwm;
        rd_word[RXWM_BIT] = ie_rxwm;
      end
      ADDR_IP: begin
        rd_word[TXWM_BIT] = txwm;
        rd_word[RXWM_BIT] = rxwm;
      end
      ADDR_DIV: rd_word[15:0] = div;
      default: ;
    endcase
  end

  // Read data held through the ack cycle
  always_ff @(posedge clk_i) begin
    if (bank_rd_en) begin
      dat_o <= rd_word;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      irq <= 1'b0;
    end else begin
      irq <= (txwm && ie_txwm) || (rxwm && ie_rxwm);
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_fifo
  import uart_serial_pkg::*;
#(
  parameter int FIFO_DEPTH = 8
) (
  input  logic                        clk_i,
  input  logic                        rst,
  input  logic                        push,
  input  byte_t                       push_data,
  input  logic                        pop,
  output byte_t                       head,
  output logic                        full,
  output logic                        empty,
  output logic [$clog2(FIFO_DEPTH):0] count
);

  localparam int AW    = $clog2(FIFO_DEPTH);
  localparam int CNT_W = AW + 1;

  byte_t         mem [FIFO_DEPTH];
  logic [AW-1:0] wr_ptr;
  logic [AW-1:0] rd_ptr;
  logic          do_push;
  logic          do_pop;

  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // Pointers wrap naturally, depth is a power of two
  always_ff @(posedge clk_i) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign head  = mem[rd_ptr];
  assign full  = (count == CNT_W'(FIFO_DEPTH));
  assign empty = (count == '0);

endmodule

`default_nettype wire

// ==== verilog/uart_reg_pkg.sv ====
`default_nettype none

package uart_reg_pkg;

  typedef logic [31:0] wb_data_t;
  typedef logic [2:0]  reg_addr_t;

  // Word addresses, SiFive layout
  localparam reg_addr_t ADDR_TXDATA = 3'd0;
  localparam reg_addr_t ADDR_RXDATA = 3'd1;
  localparam reg_addr_t ADDR_TXCTRL = 3'd2;
  localparam reg_addr_t ADDR_RXCTRL = 3'd3;
  localparam reg_addr_t ADDR_IE     = 3'd4;
  localparam reg_addr_t ADDR_IP     = 3'd5;
  localparam reg_addr_t ADDR_DIV    = 3'd6;

  // Data register flags
  localparam int FULL_BIT  = 31;
  localparam int EMPTY_BIT = 31;

  // TXCTRL and RXCTRL fields
  localparam int EN_BIT    = 0;
  localparam int NSTOP_BIT = 1;
  localparam int CNT_LSB   = 16;

  // IE and IP bits
  localparam int TXWM_BIT = 0;
  localparam int RXWM_BIT = 1;

endpackage

`default_nettype wire

// ==== verilog/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx
  import uart_serial_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst,
  input  logic  rxen,
  input  div_t  div,
  input  logic  rxd,
  output logic  rx_push,
  output byte_t rx_push_data
);

  rx_state_t  state;
  div_t       bit_cnt;
  div_t       half_div;
  logic [2:0] bit_idx;
  byte_t      shifter;
  logic       rxd_meta;
  logic       rxd_sync;
  logic       rxd_prev;
  logic       bit_done;

  assign half_div     = div >> 1;
  assign bit_done     = (bit_cnt == div);
  assign rx_push_data = shifter;

  // Line idles high
  always_ff @(posedge clk_i) begin
    if (rst) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
      rxd_prev <= 1'b1;
    end else begin
      rxd_meta <= rxd;
      rxd_sync <= rxd_meta;
      rxd_prev <= rxd_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state   <= RX_IDLE;
      bit_cnt <= '0;
      bit_idx <= '0;
      rx_push <= 1'b0;
    end else begin
      rx_push <= 1'b0;
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        RX_IDLE: begin
          bit_cnt <= '0;
          if (rxen && rxd_prev && !rxd_sync) begin
            state <= RX_START;
          end
        end
        RX_START: begin
          // Glitch shorter than half a bit goes back to idle
          if (bit_cnt == half_div) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= rxd_sync ? RX_IDLE : RX_DATA;
          end
        end
        RX_DATA: begin
          if (bit_done) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end
          end
        end
        RX_STOP: begin
          if (bit_done) begin
            rx_push <= rxd_sync;
            state   <= RX_IDLE;
          end
        end
        default: state <= RX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (state == RX_DATA && bit_done) begin
      shifter <= {rxd_sync, shifter[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_serial_pkg.sv ====
`default_nettype none

package uart_serial_pkg;

  typedef logic [7:0]  byte_t;
  typedef logic [15:0] div_t;

  typedef enum logic [1:0] {
    IDLE,
    ACCESS,
    ACK
  } bus_state_t;

  typedef enum logic [1:0] {
    TX_IDLE,
    TX_START,
    TX_DATA,
    TX_STOP
  } tx_state_t;

  typedef enum logic [1:0] {
    RX_IDLE,
    RX_START,
    RX_DATA,
    RX_STOP
  } rx_state_t;

endpackage

`default_nettype wire

// ==== verilog/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx
  import uart_serial_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst,
  input  logic  txen,
  input  logic  nstop,
  input  div_t  div,
  input  byte_t tx_head,
  input  logic  tx_empty,
  output logic  tx_pop,
  output logic  txd
);

  tx_state_t  state;
  div_t       bit_cnt;
  byte_t      shifter;
  logic [2:0] bit_idx;
  logic       stop_idx;
  logic       bit_done;
  logic       last_stop;
  logic       stop_end;

  assign tx_pop    = (state == TX_IDLE) && txen && !tx_empty;
  assign bit_done  = (bit_cnt == div);
  assign last_stop = (stop_idx == nstop);
  // Last stop bit ends a clock early, TX_IDLE supplies that clock
  assign stop_end  = (bit_cnt + 16'd1 >= div);

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state    <= TX_IDLE;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      stop_idx <= 1'b0;
      txd      <= 1'b1;
    end else begin
      bit_cnt <= bit_cnt + 1'b1;
      case (state)
        TX_IDLE: begin
          bit_cnt <= '0;
          if (tx_pop) begin
            txd   <= 1'b0;
            state <= TX_START;
          end
        end
        TX_START: begin
          if (bit_done) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= shifter[0];
            state   <= TX_DATA;
          end
        end
        TX_DATA: begin
          if (bit_done) begin
            bit_cnt <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              stop_idx <= 1'b0;
              txd      <= 1'b1;
              state    <= TX_STOP;
            end else begin
              txd <= shifter[1];
            end
          end
        end
        TX_STOP: begin
          if (last_stop && stop_end) begin
            state <= TX_IDLE;
          end else if (bit_done) begin
            bit_cnt  <= '0;
            stop_idx <= 1'b1;
          end
        end
        default: state <= TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (tx_pop) begin
      shifter <= tx_head;
    end else if (state == TX_DATA && bit_done) begin
      shifter <= {1'b0, shifter[7:1]};
    end
  end

endmodule

`default_nettype wire

// ==== verilog/uart_wb_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_wb_ctrl
  import uart_reg_pkg::*;
  import uart_serial_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst,
  input  logic      cyc_i,
  input  logic      stb_i,
  input  logic      we_i,
  input  reg_addr_t adr_i,
  input  wb_data_t  dat_i,
  output reg_addr_t addr,
  output wb_data_t  wr_data,
  output logic      bank_wr_en,
  output logic      bank_rd_en,
  output logic      ack_o
);

  bus_state_t state;
  logic       we_q;
  logic       req;

  assign req = cyc_i && stb_i;

  always_ff @(posedge clk_i) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      case (state)
        IDLE: begin
          if (req) begin
            state <= ACCESS;
          end
        end
        ACCESS: begin
          state <= ACK;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  // Request fields frozen for the rest of the transaction
  always_ff @(posedge clk_i) begin
    if (state == IDLE && req) begin
      addr    <= adr_i;
      wr_data <= dat_i;
      we_q    <= we_i;
    end
  end

  // One bank strobe per transaction
  assign bank_wr_en = (state == ACCESS) && we_q;
  assign bank_rd_en = (state == ACCESS) && !we_q;

  assign ack_o = (state == ACK);

endmodule

`default_nettype wire
